//--- flist.f
src/sdPkg.sv
src/sdCmdHandoffIf.sv
src/sdCrc7.sv
src/sdCmdTx.sv
src/sdRespRx.sv
src/sdCmdController.sv
test/tbClockGen.sv
test/tbSdCmdController.sv

//--- Bender.yml
package:
  name: sdCmdController

sources:
  - src/sdPkg.sv
  - src/sdCmdHandoffIf.sv
  - src/sdCrc7.sv
  - src/sdCmdTx.sv
  - src/sdRespRx.sv
  - src/sdCmdController.sv
  - target: test
    files:
      - test/tbClockGen.sv
      - test/tbSdCmdController.sv

//--- test/tbSdCmdController.sv
`timescale 1ns/1ps
`default_nettype none

module tbSdCmdController import sdPkg::*; ();

    localparam int TurnaroundCycles = 2;
    localparam int RandomCommands   = 6;
    localparam int NumCommands      = 9 + RandomCommands;

    logic      clk_fast;
    logic      rst;
    logic      cmdStart;
    cmdFrame_t cmdData;
    respType_e respType;
    logic      cardLine;
    logic      sdCmdOut;
    logic      sdCmdOe;
    logic      cmdDone;
    logic      respDone;
    respData_t respData;
    logic      respCrcErr;

    logic [31:0] lfsr;
    string       testName;
    int          errors = 0;
    int          checks = 0;
    int          oeCycles = 0;
    cmdFrame_t   captured;

    // Expected results queued by the stimulus and drained by the monitor
    cmdFrame_t   txExpect[$];
    respData_t   respExpect[$];
    logic        errExpect[$];

    tbClockGen clockGen (
        .clk_fast (clk_fast),
        .rst      (rst)
    );

    sdCmdController #(
        .TurnaroundCycles (TurnaroundCycles)
    ) UUT (
        .clk_fast   (clk_fast),
        .rst        (rst),
        .cmdStart   (cmdStart),
        .cmdData    (cmdData),
        .respType   (respType),
        .sdCmdIn    (cardLine),
        .sdCmdOut   (sdCmdOut),
        .sdCmdOe    (sdCmdOe),
        .cmdDone    (cmdDone),
        .respDone   (respDone),
        .respData   (respData),
        .respCrcErr (respCrcErr)
    );

    // ==================================================================
    // Helpers
    // ==================================================================
    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic nextBit();
        logic feedback;
        feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], feedback};
        return feedback;
    endfunction

    function automatic respData_t randomBits(input int count);
        respData_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[LongRespWidth-2:0], nextBit()};
        end
        return value;
    endfunction

    // Remainder of M(x) * x^7 divided by x^7 + x^3 + 1
    function automatic crc7_t refCrc7(input logic [127:0] bits, input int len);
        logic [134:0] work;
        work = {bits, 7'b0};
        for (int i = len + 6; i >= CrcWidth; i--) begin
            if (work[i]) begin
                work[i -: 8] = work[i -: 8] ^ 8'h89;
            end
        end
        return work[CrcWidth-1:0];
    endfunction

    task automatic checkValue(input string test, input string field,
                              input logic [135:0] expected, input logic [135:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s %s: expected %0h, actual %0h", test, field, expected, actual);
        end
    endtask

    // ==================================================================
    // Stimulus and card model
    // ==================================================================
    task automatic sendCommand(input respType_e kind);
        cmdFrame_t frame;
        frame = cmdFrame_t'(randomBits(CmdFrameWidth));
        txExpect.push_back({frame[47:8], refCrc7(frame[47:8], 40), 1'b1});
        @(negedge clk_fast);
        cmdStart = 1'b1;
        cmdData  = frame;
        respType = kind;
        @(negedge clk_fast);
        cmdStart = 1'b0;
        while (!cmdDone) @(negedge clk_fast);
    endtask

    // Corrupt 1 flips a CRC bit and corrupt 2 clears the end bit
    // A stray short frame follows a command that expects no response
    task automatic driveResponse(input respType_e kind, input int corrupt);
        respData_t resp;
        int        len;
        int        gap;
        int        flip;
        len  = (kind == Resp136) ? LongRespWidth : CmdFrameWidth;
        resp = randomBits(len);
        if (kind == Resp136) begin
            resp[135:128] = 8'h3f;
            resp[7:1]     = refCrc7(resp[127:8], 120);
        end else begin
            resp[47:46] = 2'b00;
            resp[7:1]   = refCrc7(resp[47:8], 40);
        end
        resp[0] = 1'b1;
        if (corrupt == 1) begin
            flip       = 1 + int'(randomBits(3) % 7);
            resp[flip] = ~resp[flip];
        end else if (corrupt == 2) begin
            resp[0] = 1'b0;
        end
        if (kind != RespNone) begin
            respExpect.push_back(resp);
            errExpect.push_back(corrupt != 0);
        end
        // Start bit must land after the turnaround has run out
        gap = int'(randomBits(3));
        repeat (TurnaroundCycles + 1 + gap) @(negedge clk_fast);
        for (int i = len - 1; i >= 0; i--) begin
            cardLine = resp[i];
            @(negedge clk_fast);
        end
        cardLine = 1'b1;
    endtask

    task automatic runCommand(input string name, input respType_e kind, input int corrupt);
        testName = name;
        sendCommand(kind);
        driveResponse(kind, corrupt);
        if (kind == RespNone) begin
            // Room for a respDone that must not come
            repeat (4) @(negedge clk_fast);
        end else begin
            while (respExpect.size() != 0) @(negedge clk_fast);
        end
    endtask

    initial begin : stimulus
        respType_e kind;
        int        corrupt;
        cmdStart = 1'b0;
        cmdData  = '0;
        respType = RespNone;
        cardLine = 1'b1;
        lfsr     = 32'hf35f9c4c;
        testName = "reset";
        wait (!rst);
        @(negedge clk_fast);
        checkValue("reset", "sdCmdOe", 0, sdCmdOe);
        checkValue("reset", "sdCmdOut", 1, sdCmdOut);
        checkValue("reset", "cmdDone", 0, cmdDone);
        checkValue("reset", "respDone", 0, respDone);
        checkValue("reset", "respData", 0, respData);
        checkValue("reset", "respCrcErr", 0, respCrcErr);

        runCommand("short", Resp48, 0);
        runCommand("long", Resp136, 0);
        runCommand("short crc", Resp48, 1);
        runCommand("short end", Resp48, 2);
        runCommand("long crc", Resp136, 1);
        runCommand("long end", Resp136, 2);
        runCommand("no response", RespNone, 0);

        // Receiver is left waiting for a start bit that never comes
        testName = "abort";
        sendCommand(Resp48);
        repeat (TurnaroundCycles + 4) @(negedge clk_fast);
        runCommand("after abort", RespNone, 0);

        for (int i = 0; i < RandomCommands; i++) begin
            kind    = randomBits(1) ? Resp136 : Resp48;
            corrupt = int'(randomBits(2) % 3);
            runCommand("random", kind, corrupt);
        end

        repeat (4) @(negedge clk_fast);
        if (respExpect.size() != 0 || txExpect.size() != 0) begin
            errors++;
            $display("Some expected frames or responses never appeared");
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // ==================================================================
    // Output monitor
    // ==================================================================
    always @(negedge clk_fast) begin
        if (!rst) begin
            if (sdCmdOe) begin
                captured = {captured[CmdFrameWidth-2:0], sdCmdOut};
                oeCycles = oeCycles + 1;
            end else if (oeCycles != 0) begin
                checkValue(testName, "sdCmdOe cycles", CmdFrameWidth, oeCycles);
                checkValue(testName, "cmdDone", 1, cmdDone);
                if (txExpect.size() == 0) begin
                    errors++;
                    $display("A frame appeared on the CMD line in %s with no command", testName);
                end else begin
                    checkValue(testName, "frame", txExpect.pop_front(), captured);
                end
                oeCycles = 0;
            end
            if (respDone) begin
                if (respExpect.size() == 0) begin
                    errors++;
                    $display("respDone pulsed in %s with no response pending", testName);
                end else begin
                    checkValue(testName, "respData", respExpect.pop_front(), respData);
                    checkValue(testName, "respCrcErr", errExpect.pop_front(), respCrcErr);
                end
            end
        end
    end

    initial begin : watchdog
        repeat (NumCommands * 200 + 100) @(posedge clk_fast);
        $display("Timeout in %s, the DUT stopped responding", testName);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
    output logic clk_fast,
    output logic rst
);

    // 10 ns period
    initial begin
        clk_fast = 1'b0;
        forever #5 clk_fast = ~clk_fast;
    end

    // Reset spans two rising edges and drops on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk_fast);
        @(negedge clk_fast);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- src/sdCmdController.sv
`timescale 1ns/1ps
`default_nettype none

module sdCmdController import sdPkg::*; #(
    parameter int TurnaroundCycles = 2
) (
    input  wire            clk_fast,
    input  wire            rst,
    input  wire            cmdStart,
    input  wire cmdFrame_t cmdData,
    input  wire respType_e respType,
    input  wire            sdCmdIn,
    output wire            sdCmdOut,
    output wire            sdCmdOe,
    output wire            cmdDone,
    output wire            respDone,
    output wire respData_t respData,
    output wire            respCrcErr
);

    // Transmitter to receiver hand-over
    sdCmdHandoffIf handoff ();

    sdCmdTx cmdTx (
        .clk_fast (clk_fast),
        .rst      (rst),
        .cmdStart (cmdStart),
        .cmdData  (cmdData),
        .respType (respType),
        .sdCmdOut (sdCmdOut),
        .sdCmdOe  (sdCmdOe),
        .cmdDone  (cmdDone),
        .handoff  (handoff.tx)
    );

    sdRespRx #(
        .TurnaroundCycles (TurnaroundCycles)
    ) respRx (
        .clk_fast   (clk_fast),
        .rst        (rst),
        .sdCmdIn    (sdCmdIn),
        .handoff    (handoff.rx),
        .respDone   (respDone),
        .respData   (respData),
        .respCrcErr (respCrcErr)
    );

endmodule

`default_nettype wire

//--- src/sdRespRx.sv
`timescale 1ns/1ps
`default_nettype none

module sdRespRx import sdPkg::*; #(
    parameter int TurnaroundCycles = 2
) (
    input  wire        clk_fast,
    input  wire        rst,
    input  wire        sdCmdIn,
    sdCmdHandoffIf.rx  handoff,
    output logic       respDone,
    output respData_t  respData,
    output logic       respCrcErr
);

    localparam int TurnWidth = $clog2(TurnaroundCycles + 2);

    respState_e           state;
    logic [TurnWidth-1:0] turnCount;
    logic [7:0]           bitCount;
    logic [7:0]           lastBit;
    logic [7:0]           crcFirst;
    logic [7:0]           crcLast;
    logic                 isLong;
    logic                 startSeen;
    logic                 sample;
    logic                 crcEnable;
    respData_t            shiftReg;
    respData_t            frameData;
    crc7_t                crc;
    logic                 crcOk;
    logic                 endOk;

    // armType holds until the next accepted command, which aborts us anyway
    assign isLong  = (handoff.armType == Resp136);
    assign lastBit = isLong ? 8'(LongRespWidth - 1) : 8'(CmdFrameWidth - 1);

    // Long responses skip the start, transmission and reserved bits
    assign crcFirst = isLong ? 8'd8 : 8'd0;
    assign crcLast  = lastBit - 8'd8;

    assign startSeen = (state == RespWait) && (turnCount == '0) && !sdCmdIn;
    assign sample    = startSeen || (state == RespShift);
    assign crcEnable = sample && (bitCount >= crcFirst) && (bitCount <= crcLast);

    // ==================================================================
    // CRC7 over the incoming bits
    // ==================================================================
    sdCrc7 respCrc (
        .clk_fast (clk_fast),
        .rst      (rst),
        .clear    (handoff.respArm),
        .enable   (crcEnable),
        .dataBit  (sdCmdIn),
        .crc      (crc)
    );

    // Bits enter at the LSB so the frame ends right-aligned
    always_ff @(posedge clk_fast) begin
        if (sample) begin
            shiftReg <= {shiftReg[LongRespWidth-2:0], sdCmdIn};
        end
    end

    // Short frames are zero-extended to the full response word
    assign frameData = isLong ? shiftReg : respData_t'(shiftReg[CmdFrameWidth-1:0]);
    assign crcOk     = (crc == shiftReg[CrcWidth:1]);
    assign endOk     = shiftReg[0];

    // ==================================================================
    // FSM
    // ==================================================================
    always_ff @(posedge clk_fast) begin
        if (rst) begin
            state      <= RespIdle;
            turnCount  <= '0;
            bitCount   <= '0;
            respDone   <= 1'b0;
            respData   <= '0;
            respCrcErr <= 1'b0;
        end else begin
            respDone <= 1'b0;
            if (handoff.cmdAbort) begin
                // New command wins over anything pending
                state <= RespIdle;
            end else if (handoff.respArm) begin
                state     <= RespWait;
                turnCount <= TurnWidth'(TurnaroundCycles);
                bitCount  <= '0;
            end else begin
                case (state)
                    RespIdle: begin
                    end
                    RespWait: begin
                        // Card and host swap line ownership here
                        if (turnCount != '0) begin
                            turnCount <= turnCount - 1'b1;
                        end else if (startSeen) begin
                            bitCount <= 8'd1;
                            state    <= RespShift;
                        end
                    end
                    RespShift: begin
                        bitCount <= bitCount + 8'd1;
                        if (bitCount == lastBit) begin
                            state <= RespCheck;
                        end
                    end
                    RespCheck: begin
                        respData   <= frameData;
                        respCrcErr <= !crcOk || !endOk;
                        respDone   <= 1'b1;
                        state      <= RespIdle;
                    end
                    default: state <= RespIdle;
                endcase
            end
        end
    end

    // Arming only ever follows the end bit driven by the transmitter
    armAfterCommand: assert property (
        @(posedge clk_fast) disable iff (rst)
        handoff.respArm |-> $past(handoff.lineDriven)
    );

endmodule

`default_nettype wire

//--- src/sdCmdTx.sv
`timescale 1ns/1ps
`default_nettype none

module sdCmdTx import sdPkg::*; (
    input  wire        clk_fast,
    input  wire        rst,
    input  wire        cmdStart,
    input  wire        cmdFrame_t cmdData,
    input  wire        respType_e respType,
    output logic       sdCmdOut,
    output logic       sdCmdOe,
    output logic       cmdDone,
    sdCmdHandoffIf.tx  handoff
);

    // Start bit, transmission bit, index and argument
    localparam int DataBits = CmdFrameWidth - 8;

    cmdState_e  state;
    cmdFrame_t  frameReg;
    logic [5:0] bitCount;
    logic       accept;
    logic       crcEnable;
    logic       crcBit;
    crc7_t      crc;

    // A start while the frame is on the line is dropped
    assign accept = cmdStart && (state == CmdIdle);

    assign handoff.cmdAbort   = accept;
    assign handoff.lineDriven = sdCmdOe;

    // ==================================================================
    // CRC7
    // ==================================================================
    // Feeding the MSB back in during CmdCrc cancels the feedback,
    // so the remainder simply shifts out MSB first
    assign crcEnable = (state == CmdShift) || (state == CmdCrc);
    assign crcBit    = (state == CmdCrc) ? crc[CrcWidth-1] : frameReg[CmdFrameWidth-1];

    sdCrc7 cmdCrc (
        .clk_fast (clk_fast),
        .rst      (rst),
        .clear    (accept),
        .enable   (crcEnable),
        .dataBit  (crcBit),
        .crc      (crc)
    );

    // ==================================================================
    // Line driver
    // ==================================================================
    always_comb begin
        case (state)
            CmdShift: sdCmdOut = frameReg[CmdFrameWidth-1];
            CmdCrc:   sdCmdOut = crc[CrcWidth-1];
            default:  sdCmdOut = 1'b1;
        endcase
    end

    always_ff @(posedge clk_fast) begin
        if (accept) begin
            frameReg <= cmdData;
        end else if (state == CmdShift) begin
            frameReg <= {frameReg[CmdFrameWidth-2:0], 1'b0};
        end
    end

    // ==================================================================
    // FSM
    // ==================================================================
    always_ff @(posedge clk_fast) begin
        if (rst) begin
            state           <= CmdIdle;
            bitCount        <= '0;
            sdCmdOe         <= 1'b0;
            cmdDone         <= 1'b0;
            handoff.respArm <= 1'b0;
            handoff.armType <= RespNone;
        end else begin
            cmdDone         <= 1'b0;
            handoff.respArm <= 1'b0;
            case (state)
                CmdIdle: begin
                    if (accept) begin
                        state           <= CmdShift;
                        bitCount        <= '0;
                        sdCmdOe         <= 1'b1;
                        handoff.armType <= respType;
                    end
                end
                CmdShift: begin
                    bitCount <= bitCount + 6'd1;
                    if (bitCount == 6'(DataBits - 1)) begin
                        bitCount <= '0;
                        state    <= CmdCrc;
                    end
                end
                CmdCrc: begin
                    bitCount <= bitCount + 6'd1;
                    if (bitCount == 6'(CrcWidth - 1)) begin
                        state <= CmdEnd;
                    end
                end
                CmdEnd: begin
                    // End bit is on the line this cycle
                    state           <= CmdIdle;
                    sdCmdOe         <= 1'b0;
                    cmdDone         <= 1'b1;
                    handoff.respArm <= (handoff.armType != RespNone);
                end
                default: state <= CmdIdle;
            endcase
        end
    end

    oeOnlyWhileBusy: assert property (
        @(posedge clk_fast) disable iff (rst)
        (state == CmdIdle) |-> !sdCmdOe
    );

endmodule

`default_nettype wire

//--- src/sdCrc7.sv
`timescale 1ns/1ps
`default_nettype none

module sdCrc7 import sdPkg::*; (
    input  wire   clk_fast,
    input  wire   rst,
    input  wire   clear,
    input  wire   enable,
    input  wire   dataBit,
    output crc7_t crc
);

    // x^7 + x^3 + 1, the x^7 term is implied by the shift
    localparam crc7_t Poly = 7'h09;

    logic feedback;

    assign feedback = dataBit ^ crc[CrcWidth-1];

    always_ff @(posedge clk_fast) begin
        if (rst || clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= {crc[CrcWidth-2:0], 1'b0} ^ (feedback ? Poly : '0);
        end
    end

endmodule

`default_nettype wire

//--- src/sdCmdHandoffIf.sv
`timescale 1ns/1ps
`default_nettype none

interface sdCmdHandoffIf import sdPkg::*; ();

    // Pulse after the end bit when a response is expected
    logic      respArm;
    // Response type of the command in flight
    respType_e armType;
    // New command accepted, drop any pending response
    logic      cmdAbort;
    // Transmitter owns the CMD line
    logic      lineDriven;

    modport tx (
        output respArm,
        output armType,
        output cmdAbort,
        output lineDriven
    );

    modport rx (
        input respArm,
        input armType,
        input cmdAbort,
        input lineDriven
    );

endinterface

`default_nettype wire

//--- src/sdPkg.sv
`default_nettype none

package sdPkg;

    // ==================================================================
    // Frame geometry
    // ==================================================================
    localparam int CmdFrameWidth = 48;
    localparam int LongRespWidth = 136;
    localparam int CrcWidth      = 7;

    // Command frame, also the layout of a short response
    typedef logic [CmdFrameWidth-1:0] cmdFrame_t;

    // Response word, short responses sit in the low 48 bits
    typedef logic [LongRespWidth-1:0] respData_t;

    typedef logic [CrcWidth-1:0] crc7_t;

    // ==================================================================
    // Encodings
    // ==================================================================
    typedef enum logic [1:0] {
        RespNone = 2'b00,
        Resp48   = 2'b01,
        Resp136  = 2'b10
    } respType_e;

    typedef enum logic [1:0] {
        CmdIdle,
        CmdShift,
        CmdCrc,
        CmdEnd
    } cmdState_e;

    typedef enum logic [1:0] {
        RespIdle,
        RespWait,
        RespShift,
        RespCheck
    } respState_e;

endpackage

`default_nettype wire
